// ==== sim.f ====
design/mem_sys_pkg.sv
design/iomem_decoder.sv
design/ram_bank.sv
design/iomem_response_merger.sv
design/mem_subsystem.sv
testbench/tb_clk_gen.sv
testbench/tb_mem_subsystem.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - files:
      - design/mem_sys_pkg.sv
      - design/iomem_decoder.sv
      - design/ram_bank.sv
      - design/iomem_response_merger.sv
      - design/mem_subsystem.sv

  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_mem_subsystem.sv

export_include_dirs: []

dependencies: {}

// ==== testbench/tb_mem_subsystem.sv ====
`default_nettype none

module tb_mem_subsystem
  import mem_sys_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_BANKS  = 4;
  localparam int BANK_DEPTH = 256;
  localparam int RAM_DELAY  = 6;
  localparam int CLK_PERIOD = 8;
  localparam int NUM_RAND   = 200;
  // Four accesses per random write plus the directed ones
  localparam int NUM_TX     = 4 * NUM_RAND + 40;
  localparam int TIMEOUT_NS = NUM_TX * (RAM_DELAY + 4) * CLK_PERIOD * 2;
  localparam logic [31:0] LFSR_SEED   = 32'hb8ac34d7;
  // Random traffic window of 4 KiB covers every bank row once
  localparam logic [31:0] WINDOW_BASE = RAM_BASE_ADDR + 32'h0000_3000;
  localparam int          WINDOW_BITS = 10;

  logic        clk_i;
  logic        rst_n;
  iomem_req_t  iomem_req;
  logic        iomem_ready;
  logic [31:0] iomem_rdata;

  logic [31:0] lfsr_q;
  int          err_cnt    = 0;
  int          done_cnt   = 0;
  int          edge_cnt   = 0;
  int          start_edge = 0;
  logic        busy       = 1'b0;
  logic [31:0] last_rdata = 32'h0;

  // Shadow RAM words and their known byte lanes
  logic [31:0] shadow_word [int];
  logic [3:0]  shadow_strb [int];

  tb_clk_gen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (3)
  ) clk_gen_i (
    .clk_o   (clk_i),
    .rst_n_o (rst_n)
  );

  mem_subsystem #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_DEPTH (BANK_DEPTH),
    .RAM_DELAY  (RAM_DELAY)
  ) mem_subsystem_i (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .iomem_req_i   (iomem_req),
    .iomem_ready_o (iomem_ready),
    .iomem_rdata_o (iomem_rdata)
  );

  ////////////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////////////

  // Galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ 32'h8020_0003;
    end
    return nxt;
  endfunction

  // One step per bit taken
  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] bits;
    bits = 32'h0;
    for (int i = 0; i < count; i++) begin
      bits[i] = lfsr_q[0];
      lfsr_q  = lfsr_next(lfsr_q);
    end
    return bits;
  endfunction

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic is_ram(input logic [31:0] addr);
    return (addr & ~RAM_MASK_ADDR) == RAM_BASE_ADDR;
  endfunction

  // Word number folded onto the banked rows
  function automatic int word_key(input logic [31:0] addr);
    return int'((addr >> 2) % (NUM_BANKS * BANK_DEPTH));
  endfunction

  // Edges from first sample to the edge that sees ready
  function automatic int expected_latency(input logic [31:0] addr);
    if (is_ram(addr)) begin
      return RAM_DELAY + 1;
    end else if (addr == TIMER_LO_ADDR || addr == TIMER_HI_ADDR) begin
      return 0;
    end
    return 1;
  endfunction

  // Expected read word with a mask of the known bits
  function automatic logic [31:0] expected_rdata(input logic [31:0] addr,
                                                 output logic [31:0] mask);
    int key;
    mask = 32'h0;
    expected_rdata = 32'h0;
    if (is_ram(addr)) begin
      key = word_key(addr);
      if (shadow_word.exists(key)) begin
        expected_rdata = shadow_word[key];
        for (int b = 0; b < 4; b++) begin
          mask[8*b +: 8] = {8{shadow_strb[key][b]}};
        end
      end
    end else if (addr != TIMER_LO_ADDR) begin
      // High timer half stays zero in a short run and unmapped reads return zero
      mask = 32'hffff_ffff;
    end
  endfunction

  function automatic void record_write(input logic [31:0] addr, input logic [3:0] wstrb,
                                       input logic [31:0] wdata);
    int          key;
    logic [31:0] word;
    logic [3:0]  known;
    key   = word_key(addr);
    word  = shadow_word.exists(key) ? shadow_word[key] : 32'h0;
    known = shadow_strb.exists(key) ? shadow_strb[key] : 4'h0;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        word[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    shadow_word[key] = word;
    shadow_strb[key] = known | wstrb;
  endfunction

  ////////////////////////////////////////////////////////////
  // Comparing process
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin : compare_proc
    int          latency;
    logic [31:0] exp_word;
    logic [31:0] exp_mask;
    if (rst_n) begin
      // Edge that first samples a request
      if (iomem_req.valid && !busy) begin
        busy       = 1'b1;
        start_edge = edge_cnt;
      end
      if (iomem_ready) begin
        assert (iomem_req.valid) else begin
          err_cnt++;
          $display("FAILED iomem_ready_o with valid low expected 0x0 actual 0x%0h",
                   iomem_ready);
        end
      end
      if (iomem_ready && iomem_req.valid) begin
        latency = edge_cnt - start_edge;
        assert (latency == expected_latency(iomem_req.addr)) else begin
          err_cnt++;
          $display("FAILED iomem_ready_o latency at 0x%08h expected 0x%0h actual 0x%0h",
                   iomem_req.addr, expected_latency(iomem_req.addr), latency);
        end
        if (iomem_req.wstrb == 4'h0) begin
          exp_word = expected_rdata(iomem_req.addr, exp_mask);
          assert ((iomem_rdata & exp_mask) === (exp_word & exp_mask)) else begin
            err_cnt++;
            $display("FAILED iomem_rdata_o at 0x%08h expected 0x%08h actual 0x%08h",
                     iomem_req.addr, exp_word & exp_mask, iomem_rdata & exp_mask);
          end
        end else if (is_ram(iomem_req.addr)) begin
          record_write(iomem_req.addr, iomem_req.wstrb, iomem_req.wdata);
        end
        last_rdata = iomem_rdata;
        busy       = 1'b0;
        done_cnt++;
      end
      edge_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Driver
  ////////////////////////////////////////////////////////////

  // Request held until the comparing process sees it complete
  task automatic bus_access(input logic [31:0] addr, input logic [3:0] wstrb,
                            input logic [31:0] wdata);
    int seen;
    @(negedge clk_i);
    seen            = done_cnt;
    iomem_req.valid = 1'b1;
    iomem_req.wstrb = wstrb;
    iomem_req.addr  = addr;
    iomem_req.wdata = wdata;
    wait (done_cnt != seen);
  endtask

  task automatic bus_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      iomem_req.valid = 1'b0;
    end
  endtask

  // Two low timer reads gap cycles apart
  task automatic check_timer_gap(input int gap);
    logic [31:0] first;
    logic [31:0] second;
    bus_access(TIMER_LO_ADDR, 4'h0, 32'h0);
    first = last_rdata;
    bus_idle(gap - 1);
    bus_access(TIMER_LO_ADDR, 4'h0, 32'h0);
    second = last_rdata;
    assert (second - first == 32'(gap)) else begin
      err_cnt++;
      $display("FAILED iomem_rdata_o timer delta expected 0x%08h actual 0x%08h",
               gap, second - first);
    end
  endtask

  initial begin : main_seq
    logic [31:0] wr_word;
    logic [31:0] rd_word;
    logic [3:0]  wr_strb;
    logic [31:0] wr_data;
    iomem_req = '0;
    lfsr_q    = LFSR_SEED;
    wait (rst_n === 1'b1);

    // Ready must stay low on a quiet bus
    bus_idle(6);

    // Random write with its readback, the neighbor in the next bank and a random read
    for (int i = 0; i < NUM_RAND; i++) begin
      wr_word = take_bits(WINDOW_BITS);
      wr_strb = 4'(take_bits(4));
      if (wr_strb == 4'h0) begin
        wr_strb = 4'hf;
      end
      wr_data = take_bits(32);
      rd_word = take_bits(WINDOW_BITS);
      bus_access(WINDOW_BASE + (wr_word << 2), wr_strb, wr_data);
      bus_access(WINDOW_BASE + (wr_word << 2), 4'h0, 32'h0);
      bus_access(WINDOW_BASE + ((wr_word ^ 32'h1) << 2), 4'h0, 32'h0);
      bus_access(WINDOW_BASE + (rd_word << 2), 4'h0, 32'h0);
    end
    bus_idle(3);

    // Both timer halves answer at once
    check_timer_gap(1);
    check_timer_gap(2);
    check_timer_gap(5);
    check_timer_gap(13);
    bus_access(TIMER_HI_ADDR, 4'h0, 32'h0);
    bus_idle(2);

    // Unmapped reads and then writes that must not reach RAM
    bus_access(32'h0000_0040, 4'h0, 32'h0);
    bus_access(32'h3000_0008, 4'h0, 32'h0);
    bus_access(32'h4010_0040, 4'h0, 32'h0);
    bus_access(RAM_BASE_ADDR + 32'h40, 4'hf, 32'hcafe_f00d);
    bus_access(32'h0000_0040, 4'hf, 32'h1234_5678);
    bus_access(32'h4010_0040, 4'h3, 32'h8765_4321);
    bus_access(RAM_BASE_ADDR + 32'h40, 4'h0, 32'h0);
    bus_idle(4);

    $display("Run complete: %0d accesses, %0d errors", done_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, an access never completed", TIMEOUT_NS);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset held over the first rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== design/mem_subsystem.sv ====
`default_nettype none

module mem_subsystem
  import mem_sys_pkg::*;
#(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_DEPTH = 256,
  parameter int RAM_DELAY  = 16
) (
  input  logic        clk_i,
  input  logic        rst_n,
  input  iomem_req_t  iomem_req_i,
  output logic        iomem_ready_o,
  output logic [31:0] iomem_rdata_o
);

  // Bank interleave needs a power of two
  if ((NUM_BANKS < 1) || ((NUM_BANKS & (NUM_BANKS - 1)) != 0)) begin : g_bad_banks
    $error("NUM_BANKS must be a power of two");
  end

  bank_req_t bank_req [NUM_BANKS];
  bank_rsp_t bank_rsp [NUM_BANKS];
  region_t   region;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  iomem_decoder #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_DEPTH (BANK_DEPTH)
  ) decoder_i (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .iomem_req_i   (iomem_req_i),
    .access_done_i (iomem_ready_o),
    .bank_req_o    (bank_req),
    .region_o      (region)
  );

  // Word interleaved banks
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    ram_bank #(
      .BANK_DEPTH (BANK_DEPTH),
      .RAM_DELAY  (RAM_DELAY)
    ) bank_i (
      .clk_i      (clk_i),
      .rst_n      (rst_n),
      .bank_req_i (bank_req[b]),
      .bank_rsp_o (bank_rsp[b])
    );
  end

  ////////////////////////////////////////////////////////////
  // Response side, also hosts the timer
  ////////////////////////////////////////////////////////////

  iomem_response_merger #(
    .NUM_BANKS (NUM_BANKS)
  ) merger_i (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .iomem_req_i   (iomem_req_i),
    .region_i      (region),
    .bank_rsp_i    (bank_rsp),
    .iomem_ready_o (iomem_ready_o),
    .iomem_rdata_o (iomem_rdata_o)
  );

endmodule

`default_nettype wire

// ==== design/iomem_response_merger.sv ====
`default_nettype none

module iomem_response_merger
  import mem_sys_pkg::*;
#(
  parameter int NUM_BANKS = 4
) (
  input  logic        clk_i,
  input  logic        rst_n,
  input  iomem_req_t  iomem_req_i,
  input  region_t     region_i,
  input  bank_rsp_t   bank_rsp_i [NUM_BANKS],
  output logic        iomem_ready_o,
  output logic [31:0] iomem_rdata_o
);

  logic [63:0]          timer_q;
  logic [NUM_BANKS-1:0] bank_ready;
  logic [31:0]          bank_rdata;
  logic                 timer_hit;
  logic [31:0]          timer_word;
  logic                 unmapped_q;

  ////////////////////////////////////////////////////////////
  // Bank responses
  ////////////////////////////////////////////////////////////

  // Idle banks drive zero data, so a plain OR is enough
  always_comb begin
    bank_rdata = 32'h0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_ready[b] = bank_rsp_i[b].ready;
      bank_rdata    = bank_rdata | bank_rsp_i[b].rdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Cycle timer
  ////////////////////////////////////////////////////////////

  // Free running, zero in the first cycle out of reset
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      timer_q <= 64'h0;
    end else begin
      timer_q <= timer_q + 64'h1;
    end
  end

  assign timer_hit  = iomem_req_i.valid &&
                      ((region_i == REGION_TIMER_LO) || (region_i == REGION_TIMER_HI));
  assign timer_word = (region_i == REGION_TIMER_HI) ? timer_q[63:32] : timer_q[31:0];

  // Unmapped access, ready one cycle after first sample
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      unmapped_q <= 1'b0;
    end else begin
      unmapped_q <= iomem_req_i.valid && (region_i == REGION_NONE) && !unmapped_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Port outputs
  ////////////////////////////////////////////////////////////

  assign iomem_ready_o = (|bank_ready) || timer_hit || unmapped_q;
  // Unmapped reads fall through to the zero bank data
  assign iomem_rdata_o = timer_hit ? timer_word : bank_rdata;

  // Only one responder may finish an access
  assert property (@(posedge clk_i) disable iff (!rst_n)
    $onehot0({bank_ready, timer_hit, unmapped_q}));

endmodule

`default_nettype wire

// ==== design/ram_bank.sv ====
`default_nettype none

module ram_bank
  import mem_sys_pkg::*;
#(
  parameter int BANK_DEPTH = 256,
  parameter int RAM_DELAY  = 16
) (
  input  logic      clk_i,
  input  logic      rst_n,
  input  bank_req_t bank_req_i,
  output bank_rsp_t bank_rsp_o
);

  localparam int IDX_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;
  localparam int CNT_W = $clog2(RAM_DELAY + 1);

  // Storage with separately written byte lanes
  logic [31:0] mem_q [BANK_DEPTH];

  bank_state_t state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             start;
  logic             delay_done;

  // Latched access
  logic [3:0]       wstrb_q;
  logic [IDX_W-1:0] index_q;
  logic [31:0]      wdata_q;
  logic [31:0]      rdata_q;

  assign start      = bank_req_i.valid && (state_q == BANK_IDLE);
  assign delay_done = (state_q == BANK_WAIT) && (cnt_q == CNT_W'(RAM_DELAY));

  ////////////////////////////////////////////////////////////
  // Latency sequencer
  ////////////////////////////////////////////////////////////

  // cnt_q holds the number of the next edge after the start edge
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q <= BANK_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        BANK_IDLE: begin
          if (start) begin
            state_q <= BANK_WAIT;
            cnt_q   <= CNT_W'(1);
          end
        end
        BANK_WAIT: begin
          if (delay_done) begin
            state_q <= BANK_DONE;
          end else begin
            cnt_q <= cnt_q + CNT_W'(1);
          end
        end
        // Ready lasts a single cycle
        BANK_DONE: state_q <= BANK_IDLE;
        default:   state_q <= BANK_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath and storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (start) begin
      wstrb_q <= bank_req_i.wstrb;
      index_q <= bank_req_i.index[IDX_W-1:0];
      wdata_q <= bank_req_i.wdata;
    end
    // Read word is ready with the DONE state
    if (delay_done) begin
      rdata_q <= mem_q[index_q];
    end
    // Strobed bytes land at the edge closing the DONE cycle
    if (state_q == BANK_DONE) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb_q[b]) begin
          mem_q[index_q][8*b +: 8] <= wdata_q[8*b +: 8];
        end
      end
    end
  end

  // Zero outside DONE so the merger can OR all banks
  assign bank_rsp_o.ready = (state_q == BANK_DONE);
  assign bank_rsp_o.rdata = (state_q == BANK_DONE) ? rdata_q : 32'h0;

  // Decoder must not start a bank that is still busy
  assert property (@(posedge clk_i) disable iff (!rst_n)
    bank_req_i.valid |-> state_q == BANK_IDLE);

  // Ready arrives RAM_DELAY + 1 edges after the start edge for one cycle
  assert property (@(posedge clk_i) disable iff (!rst_n)
    start |-> ##(RAM_DELAY + 1) (bank_rsp_o.ready ##1 !bank_rsp_o.ready));

endmodule

`default_nettype wire

// ==== design/iomem_decoder.sv ====
`default_nettype none

module iomem_decoder
  import mem_sys_pkg::*;
#(
  parameter int NUM_BANKS  = 4,
  parameter int BANK_DEPTH = 256
) (
  input  logic       clk_i,
  input  logic       rst_n,
  input  iomem_req_t iomem_req_i,
  input  logic       access_done_i,
  output bank_req_t  bank_req_o [NUM_BANKS],
  output region_t    region_o
);

  // Bank select width is at least one bit
  localparam int SEL_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  logic [29:0]          word_num;
  logic [SEL_W-1:0]     bank_sel;
  logic [15:0]          bank_index;
  logic                 ram_hit;
  logic                 issued_q;
  logic                 new_ram_req;
  logic [NUM_BANKS-1:0] bank_valid;

  ////////////////////////////////////////////////////////////
  // Region and word split
  ////////////////////////////////////////////////////////////

  assign ram_hit = (iomem_req_i.addr & ~RAM_MASK_ADDR) == RAM_BASE_ADDR;

  always_comb begin
    if (ram_hit) begin
      region_o = REGION_RAM;
    end else if (iomem_req_i.addr == TIMER_LO_ADDR) begin
      region_o = REGION_TIMER_LO;
    end else if (iomem_req_i.addr == TIMER_HI_ADDR) begin
      region_o = REGION_TIMER_HI;
    end else begin
      region_o = REGION_NONE;
    end
  end

  // Low word bits pick the bank and the next bits the row
  assign word_num   = iomem_req_i.addr[31:2];
  assign bank_sel   = SEL_W'(word_num % NUM_BANKS);
  assign bank_index = 16'((word_num / NUM_BANKS) % BANK_DEPTH);

  ////////////////////////////////////////////////////////////
  // Issue tracking
  ////////////////////////////////////////////////////////////

  // Set once a held request has been sampled
  // Cleared in the completing cycle so the next request is fresh
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      issued_q <= 1'b0;
    end else begin
      issued_q <= iomem_req_i.valid && !access_done_i;
    end
  end

  assign new_ram_req = iomem_req_i.valid && ram_hit && !issued_q;

  // Only the owning bank sees valid
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_valid[b]          = new_ram_req && (bank_sel == SEL_W'(b));
      bank_req_o[b].valid    = bank_valid[b];
      bank_req_o[b].wstrb    = iomem_req_i.wstrb;
      bank_req_o[b].index    = bank_index;
      bank_req_o[b].wdata    = iomem_req_i.wdata;
    end
  end

  // A held request never pulses a bank twice
  assert property (@(posedge clk_i) disable iff (!rst_n) |bank_valid |=> !(|bank_valid));

endmodule

`default_nettype wire

// ==== design/mem_sys_pkg.sv ====
`default_nettype none

package mem_sys_pkg;

  ////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////

  // Main RAM window, offset bits alias inside the banks
  localparam logic [31:0] RAM_BASE_ADDR = 32'h4000_0000;
  localparam logic [31:0] RAM_MASK_ADDR = 32'h000F_FFFF;

  // Cycle timer halves
  localparam logic [31:0] TIMER_LO_ADDR = 32'h3000_0000;
  localparam logic [31:0] TIMER_HI_ADDR = 32'h3000_0004;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    REGION_NONE     = 2'd0,
    REGION_RAM      = 2'd1,
    REGION_TIMER_LO = 2'd2,
    REGION_TIMER_HI = 2'd3
  } region_t;

  typedef enum logic [1:0] {
    BANK_IDLE = 2'd0,
    BANK_WAIT = 2'd1,
    BANK_DONE = 2'd2
  } bank_state_t;

  // Processor side request, zero wstrb means read
  typedef struct packed {
    logic        valid;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } iomem_req_t;

  // Per bank request, valid is a single cycle pulse
  typedef struct packed {
    logic        valid;
    logic [3:0]  wstrb;
    logic [15:0] index;
    logic [31:0] wdata;
  } bank_req_t;

  // Per bank response, rdata is zero unless ready
  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } bank_rsp_t;

endpackage

`default_nettype wire
